/* hdl/decoder.sv */
// rv32i main decoder
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module decoder (
    input  rv_pipe_pkg::instr_t       instr_i,
    input  logic                      valid_i,      // low for a bubble
    output logic                      reg_w_o,      // writes rd, never for x0
    output logic                      jump_o,       // jal
    output logic                      branch_o,     // conditional branch
    output logic                      alu_src_o,    // operand b is the immediate
    output logic                      a_is_pc_o,    // operand a is the pc, auipc
    output rv_pipe_pkg::result_src_t  result_src_o,
    output rv_pipe_pkg::alu_ctrl_t    alu_ctrl_o,
    output logic [2:0]                funct3_o,     // branch condition
    output rv_pipe_pkg::data_t        ext_imm_o,
    output rv_pipe_pkg::reg_idx_t     rs1_o,
    output rv_pipe_pkg::reg_idx_t     rs2_o,
    output rv_pipe_pkg::reg_idx_t     rd_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic               funct7_b5;   // sub and sra select
    rv_pipe_pkg::data_t imm_i;
    rv_pipe_pkg::data_t imm_b;
    rv_pipe_pkg::data_t imm_u;
    rv_pipe_pkg::data_t imm_j;

    // alu op shared by op and op-imm, alt picks sub or sra
    function automatic rv_pipe_pkg::alu_ctrl_t alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_op = alt ? `ALU_SUB : `ALU_ADD;
            3'b001:  alu_op = `ALU_SLL;
            3'b010:  alu_op = `ALU_SLT;
            3'b011:  alu_op = `ALU_SLTU;
            3'b100:  alu_op = `ALU_XOR;
            3'b101:  alu_op = alt ? `ALU_SRA : `ALU_SRL;
            3'b110:  alu_op = `ALU_OR;
            default: alu_op = `ALU_AND;
        endcase
    endfunction

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rs1_o     = instr_i[19:15];
    assign rs2_o     = instr_i[24:20];
    assign rd_o      = instr_i[11:7];
    assign funct3_o  = funct3;

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        reg_w_o      = 1'b0;           // anything unknown is a no-op
        jump_o       = 1'b0;
        branch_o     = 1'b0;
        alu_src_o    = 1'b0;
        a_is_pc_o    = 1'b0;
        result_src_o = `RES_ALU;
        alu_ctrl_o   = `ALU_ADD;
        ext_imm_o    = '0;
        if (valid_i) begin
            case (opcode)
                7'b0110011: begin      // op
                    reg_w_o    = 1'b1;
                    alu_ctrl_o = alu_op(funct3, funct7_b5);
                end
                7'b0010011: begin      // op-imm, srai only for funct3 101
                    reg_w_o    = 1'b1;
                    alu_src_o  = 1'b1;
                    alu_ctrl_o = alu_op(funct3, funct7_b5 & (funct3 == 3'b101));
                    ext_imm_o  = imm_i;
                end
                7'b0110111: begin      // lui
                    reg_w_o    = 1'b1;
                    alu_src_o  = 1'b1;
                    alu_ctrl_o = `ALU_PASSB;
                    ext_imm_o  = imm_u;
                end
                7'b0010111: begin      // auipc
                    reg_w_o    = 1'b1;
                    alu_src_o  = 1'b1;
                    a_is_pc_o  = 1'b1;
                    ext_imm_o  = imm_u;
                end
                7'b1100011: begin      // branch, funct3 01x is illegal
                    branch_o   = (funct3[2:1] != 2'b01);
                    ext_imm_o  = imm_b;
                end
                7'b1101111: begin      // jal
                    reg_w_o      = 1'b1;
                    jump_o       = 1'b1;
                    result_src_o = `RES_PC4;
                    ext_imm_o    = imm_j;
                end
                default: ;
            endcase
        end
        if (rd_o == 5'd0)
            reg_w_o = 1'b0;            // x0 never written
    end

endmodule

/* hdl/fetch_unit.sv */
// fetch stage
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module fetch_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                redirect_i,   // taken branch or jal in execute
    input  rv_pipe_pkg::addr_t  target_i,     // where to fetch after redirect
    input  logic                flush_i,      // kill the word being fetched
    input  rv_pipe_pkg::instr_t imem_rdata_i, // same-cycle answer to imem_addr_o
    output rv_pipe_pkg::addr_t  imem_addr_o,
    output rv_pipe_pkg::instr_t instr_o,      // decode-stage word
    output rv_pipe_pkg::addr_t  pc_o,
    output rv_pipe_pkg::addr_t  pc_plus4_o,
    output logic                valid_o
);

    rv_pipe_pkg::addr_t pc_f;       // fetch pc
    rv_pipe_pkg::addr_t pc_plus4_f; // sequential next pc

    assign pc_plus4_f  = pc_f + 32'd4;
    assign imem_addr_o = pc_f;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_f    <= `RV_RESET_PC;
            valid_o <= 1'b0;                                 // decode empty after reset
        end else begin
            pc_f    <= redirect_i ? target_i : pc_plus4_f;
            valid_o <= !flush_i;                             // flushed slot becomes a bubble
        end
    end

    // fetch-to-decode payload
    always_ff @(posedge clk_i) begin
        instr_o    <= imem_rdata_i;
        pc_o       <= pc_f;
        pc_plus4_o <= pc_plus4_f;
    end

endmodule

/* hdl/reg_d_to_e.sv */
// decode to execute register
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module reg_d_to_e (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,        // redirect from execute
    input  logic                     valid_i,
    input  logic                     reg_w_d_i,
    input  logic                     jump_d_i,
    input  logic                     branch_d_i,
    input  logic                     alu_src_d_i,
    input  logic                     a_is_pc_d_i,
    input  rv_pipe_pkg::result_src_t result_src_d_i,
    input  rv_pipe_pkg::alu_ctrl_t   alu_ctrl_d_i,
    input  logic [2:0]               funct3_d_i,
    input  rv_pipe_pkg::data_t       rd1_d_i,        // register reads from decode
    input  rv_pipe_pkg::data_t       rd2_d_i,
    input  rv_pipe_pkg::reg_idx_t    rs1_d_i,
    input  rv_pipe_pkg::reg_idx_t    rs2_d_i,
    input  rv_pipe_pkg::reg_idx_t    rd_d_i,
    input  rv_pipe_pkg::data_t       ext_imm_d_i,
    input  rv_pipe_pkg::addr_t       pc_d_i,
    input  rv_pipe_pkg::addr_t       pc_plus4_d_i,
    output logic                     valid_e_o,
    output logic                     reg_w_e_o,
    output logic                     jump_e_o,
    output logic                     branch_e_o,
    output logic                     alu_src_e_o,
    output logic                     a_is_pc_e_o,
    output rv_pipe_pkg::result_src_t result_src_e_o,
    output rv_pipe_pkg::alu_ctrl_t   alu_ctrl_e_o,
    output logic [2:0]               funct3_e_o,
    output rv_pipe_pkg::data_t       rd1_e_o,
    output rv_pipe_pkg::data_t       rd2_e_o,
    output rv_pipe_pkg::reg_idx_t    rs1_e_o,
    output rv_pipe_pkg::reg_idx_t    rs2_e_o,
    output rv_pipe_pkg::reg_idx_t    rd_e_o,
    output rv_pipe_pkg::data_t       ext_imm_e_o,
    output rv_pipe_pkg::addr_t       pc_e_o,
    output rv_pipe_pkg::addr_t       pc_plus4_e_o
);

    // control side becomes a bubble on flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_e_o      <= 1'b0;                  // execute empty after reset
            reg_w_e_o      <= 1'b0;
            jump_e_o       <= 1'b0;
            branch_e_o     <= 1'b0;
            alu_src_e_o    <= 1'b0;
            a_is_pc_e_o    <= 1'b0;
            result_src_e_o <= `RES_ALU;
            alu_ctrl_e_o   <= `ALU_ADD;
            funct3_e_o     <= 3'b000;
        end else if (flush_i) begin
            valid_e_o      <= 1'b0;                  // younger slot squashed by redirect
            reg_w_e_o      <= 1'b0;
            jump_e_o       <= 1'b0;
            branch_e_o     <= 1'b0;
            alu_src_e_o    <= 1'b0;
            a_is_pc_e_o    <= 1'b0;
            result_src_e_o <= `RES_ALU;
            alu_ctrl_e_o   <= `ALU_ADD;
            funct3_e_o     <= 3'b000;
        end else begin
            valid_e_o      <= valid_i;
            reg_w_e_o      <= reg_w_d_i;
            jump_e_o       <= jump_d_i;
            branch_e_o     <= branch_d_i;
            alu_src_e_o    <= alu_src_d_i;
            a_is_pc_e_o    <= a_is_pc_d_i;
            result_src_e_o <= result_src_d_i;
            alu_ctrl_e_o   <= alu_ctrl_d_i;
            funct3_e_o     <= funct3_d_i;
        end
    end

    // data side, harmless in a bubble since controls are low
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd1_e_o      <= '0;
            rd2_e_o      <= '0;
            rs1_e_o      <= '0;
            rs2_e_o      <= '0;
            rd_e_o       <= '0;
            ext_imm_e_o  <= '0;
            pc_e_o       <= '0;
            pc_plus4_e_o <= '0;
        end else begin
            rd1_e_o      <= rd1_d_i;                 // operands read in decode
            rd2_e_o      <= rd2_d_i;
            rs1_e_o      <= rs1_d_i;                 // kept for forwarding compare
            rs2_e_o      <= rs2_d_i;
            rd_e_o       <= rd_d_i;
            ext_imm_e_o  <= ext_imm_d_i;
            pc_e_o       <= pc_d_i;
            pc_plus4_e_o <= pc_plus4_d_i;            // jal link value
        end
    end

endmodule

/* hdl/reg_file.sv */
// register file
`timescale 1ns/100ps

module reg_file (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  we_i,      // writeback enable
    input  rv_pipe_pkg::reg_idx_t waddr_i,
    input  rv_pipe_pkg::reg_idx_t raddr1_i,
    input  rv_pipe_pkg::reg_idx_t raddr2_i,
    input  rv_pipe_pkg::data_t    wdata_i,
    output rv_pipe_pkg::data_t    rdata1_o,
    output rv_pipe_pkg::data_t    rdata2_o
);

    rv_pipe_pkg::data_t regs [32];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;                  // x0 stays zero
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rdata1_o = (raddr1_i == 5'd0)                 ? '0      :
                      (we_i && raddr1_i == waddr_i)      ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0)                 ? '0      :
                      (we_i && raddr2_i == waddr_i)      ? wdata_i : regs[raddr2_i];

endmodule

/* hdl/rv_pipe_defs.svh */
// rv32i pipeline constants
`ifndef RV_PIPE_DEFS_SVH
`define RV_PIPE_DEFS_SVH

`define RV_ADDR_W   32              // pc and target width
`define RV_DATA_W   32              // register and operand width
`define RV_RESET_PC 32'h0000_0000   // first fetch address

`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_SLL   4'd5
`define ALU_SRL   4'd6
`define ALU_SRA   4'd7
`define ALU_SLT   4'd8
`define ALU_SLTU  4'd9
`define ALU_PASSB 4'd10             // operand b straight through, lui

`define RES_ALU 2'b00               // writeback takes alu result
`define RES_MEM 2'b01               // reserved, no data memory here
`define RES_PC4 2'b10               // writeback takes pc+4, jal link

`endif

/* hdl/rv_pipe_pkg.sv */
// rv32i pipeline types
`include "rv_pipe_defs.svh"

package rv_pipe_pkg;

    typedef logic [`RV_ADDR_W-1:0] addr_t;     // pc or branch target
    typedef logic [`RV_DATA_W-1:0] data_t;     // register value, operand, immediate
    typedef logic [4:0]            reg_idx_t;  // x0..x31
    typedef logic [3:0]            alu_ctrl_t; // one of the ALU_* codes
    typedef logic [1:0]            result_src_t; // one of the RES_* codes
    typedef logic [31:0]           instr_t;    // raw instruction word

endpackage

/* hdl/rv_pipe_top.sv */
// rv32i pipeline top
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module rv_pipe_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_pipe_pkg::instr_t   imem_rdata_i,
    output rv_pipe_pkg::addr_t    imem_addr_o,
    output logic                  retire_valid_o,
    output rv_pipe_pkg::addr_t    retire_pc_o,
    output logic                  retire_we_o,
    output rv_pipe_pkg::reg_idx_t retire_rd_o,
    output rv_pipe_pkg::data_t    retire_data_o
);

    // fetch / decode
    rv_pipe_pkg::instr_t      instr_d;
    rv_pipe_pkg::addr_t       pc_d, pc_plus4_d;
    logic                     valid_d;
    logic                     reg_w_d, jump_d, branch_d, alu_src_d, a_is_pc_d;
    rv_pipe_pkg::result_src_t result_src_d;
    rv_pipe_pkg::alu_ctrl_t   alu_ctrl_d;
    logic [2:0]               funct3_d;
    rv_pipe_pkg::data_t       ext_imm_d, rd1_d, rd2_d;
    rv_pipe_pkg::reg_idx_t    rs1_d, rs2_d, rd_d;

    // execute
    logic                     valid_e, reg_w_e, jump_e, branch_e, alu_src_e, a_is_pc_e;
    rv_pipe_pkg::result_src_t result_src_e;
    rv_pipe_pkg::alu_ctrl_t   alu_ctrl_e;
    logic [2:0]               funct3_e;
    rv_pipe_pkg::data_t       rd1_e, rd2_e, ext_imm_e;
    rv_pipe_pkg::reg_idx_t    rs1_e, rs2_e, rd_e;
    rv_pipe_pkg::addr_t       pc_e, pc_plus4_e;
    rv_pipe_pkg::data_t       src_a, src_b, fwd1, fwd2, alu_y, result_e;
    logic                     cond_e, redirect;
    rv_pipe_pkg::addr_t       target_e;

    fetch_unit u_fetch (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect),
        .target_i     (target_e),
        .flush_i      (redirect),
        .imem_rdata_i (imem_rdata_i),
        .imem_addr_o  (imem_addr_o),
        .instr_o      (instr_d),
        .pc_o         (pc_d),
        .pc_plus4_o   (pc_plus4_d),
        .valid_o      (valid_d)
    );

    decoder u_dec (
        .instr_i      (instr_d),
        .valid_i      (valid_d),
        .reg_w_o      (reg_w_d),
        .jump_o       (jump_d),
        .branch_o     (branch_d),
        .alu_src_o    (alu_src_d),
        .a_is_pc_o    (a_is_pc_d),
        .result_src_o (result_src_d),
        .alu_ctrl_o   (alu_ctrl_d),
        .funct3_o     (funct3_d),
        .ext_imm_o    (ext_imm_d),
        .rs1_o        (rs1_d),
        .rs2_o        (rs2_d),
        .rd_o         (rd_d)
    );

    reg_file u_rf (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (retire_we_o),
        .waddr_i  (retire_rd_o),
        .raddr1_i (rs1_d),
        .raddr2_i (rs2_d),
        .wdata_i  (retire_data_o),
        .rdata1_o (rd1_d),
        .rdata2_o (rd2_d)
    );

    reg_d_to_e u_de (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (redirect),
        .valid_i        (valid_d),
        .reg_w_d_i      (reg_w_d),
        .jump_d_i       (jump_d),
        .branch_d_i     (branch_d),
        .alu_src_d_i    (alu_src_d),
        .a_is_pc_d_i    (a_is_pc_d),
        .result_src_d_i (result_src_d),
        .alu_ctrl_d_i   (alu_ctrl_d),
        .funct3_d_i     (funct3_d),
        .rd1_d_i        (rd1_d),
        .rd2_d_i        (rd2_d),
        .rs1_d_i        (rs1_d),
        .rs2_d_i        (rs2_d),
        .rd_d_i         (rd_d),
        .ext_imm_d_i    (ext_imm_d),
        .pc_d_i         (pc_d),
        .pc_plus4_d_i   (pc_plus4_d),
        .valid_e_o      (valid_e),
        .reg_w_e_o      (reg_w_e),
        .jump_e_o       (jump_e),
        .branch_e_o     (branch_e),
        .alu_src_e_o    (alu_src_e),
        .a_is_pc_e_o    (a_is_pc_e),
        .result_src_e_o (result_src_e),
        .alu_ctrl_e_o   (alu_ctrl_e),
        .funct3_e_o     (funct3_e),
        .rd1_e_o        (rd1_e),
        .rd2_e_o        (rd2_e),
        .rs1_e_o        (rs1_e),
        .rs2_e_o        (rs2_e),
        .rd_e_o         (rd_e),
        .ext_imm_e_o    (ext_imm_e),
        .pc_e_o         (pc_e),
        .pc_plus4_e_o   (pc_plus4_e)
    );

    // forward from the writeback stage
    assign fwd1 = (retire_we_o && rs1_e != 5'd0 && rs1_e == retire_rd_o) ? retire_data_o : rd1_e;
    assign fwd2 = (retire_we_o && rs2_e != 5'd0 && rs2_e == retire_rd_o) ? retire_data_o : rd2_e;

    assign src_a = a_is_pc_e ? pc_e : fwd1;
    assign src_b = alu_src_e ? ext_imm_e : fwd2;

    always_comb begin
        case (alu_ctrl_e)
            `ALU_ADD:   alu_y = src_a + src_b;
            `ALU_SUB:   alu_y = src_a - src_b;
            `ALU_AND:   alu_y = src_a & src_b;
            `ALU_OR:    alu_y = src_a | src_b;
            `ALU_XOR:   alu_y = src_a ^ src_b;
            `ALU_SLL:   alu_y = src_a << src_b[4:0];
            `ALU_SRL:   alu_y = src_a >> src_b[4:0];
            `ALU_SRA:   alu_y = rv_pipe_pkg::data_t'($signed(src_a) >>> src_b[4:0]);
            `ALU_SLT:   alu_y = {31'b0, $signed(src_a) < $signed(src_b)};
            `ALU_SLTU:  alu_y = {31'b0, src_a < src_b};
            `ALU_PASSB: alu_y = src_b;
            default:    alu_y = '0;
        endcase
    end

    always_comb begin
        case (funct3_e)
            3'b000:  cond_e = (fwd1 == fwd2);
            3'b001:  cond_e = (fwd1 != fwd2);
            3'b100:  cond_e = ($signed(fwd1) < $signed(fwd2));
            3'b101:  cond_e = ($signed(fwd1) >= $signed(fwd2));
            3'b110:  cond_e = (fwd1 < fwd2);
            default: cond_e = (fwd1 >= fwd2);
        endcase
    end

    assign target_e = pc_e + ext_imm_e;
    assign redirect = valid_e && (jump_e || (branch_e && cond_e));
    assign result_e = (result_src_e == `RES_PC4) ? pc_plus4_e : alu_y;

    // execute to writeback
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
            retire_we_o    <= 1'b0;
            retire_pc_o    <= '0;
            retire_rd_o    <= '0;
            retire_data_o  <= '0;
        end else begin
            retire_valid_o <= valid_e;
            retire_we_o    <= valid_e && reg_w_e;
            retire_pc_o    <= pc_e;
            retire_rd_o    <= rd_e;
            retire_data_o  <= result_e;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the rv32i pipeline testbench with verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_rv_pipe -o tb_rv_pipe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_pipe > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TEST PASSED" "$LOG"; then
    echo "no result line in $LOG"
    exit 1
fi

exit 0

/* sim/tb_rv_pipe.sv */
// rv32i pipeline testbench
`timescale 1ns/100ps
`include "rv_pipe_defs.svh"

module tb_rv_pipe;

    localparam int PROG_LEN = 200;                 // last slot holds the self jal
    localparam int MEM_WORDS = 256;
    localparam int RUN_LIMIT = 2000;               // cycles before retirement is called stalled
    localparam int K_R = 0, K_I = 1, K_LUI = 2, K_AUIPC = 3, K_BR = 4, K_JAL = 5;

    logic                          clk_i;
    logic                          rst_n_i;
    rv_pipe_pkg::instr_t           imem_rdata_i;
    rv_pipe_pkg::addr_t            imem_addr_o;
    logic                          retire_valid_o;
    rv_pipe_pkg::addr_t            retire_pc_o;
    logic                          retire_we_o;
    rv_pipe_pkg::reg_idx_t         retire_rd_o;
    rv_pipe_pkg::data_t            retire_data_o;

    rv_pipe_pkg::instr_t           imem [MEM_WORDS];
    int                            kind_a [PROG_LEN];   // per slot, what was generated
    logic [2:0]                    f3_a [PROG_LEN];
    logic                          alt_a [PROG_LEN];    // sub or sra
    rv_pipe_pkg::reg_idx_t         rd_a [PROG_LEN];
    rv_pipe_pkg::reg_idx_t         rs1_a [PROG_LEN];
    rv_pipe_pkg::reg_idx_t         rs2_a [PROG_LEN];
    rv_pipe_pkg::data_t            imm_a [PROG_LEN];    // already extended and shifted

    rv_pipe_pkg::addr_t            exp_pc [$];          // expected retire stream
    logic                          exp_we [$];
    rv_pipe_pkg::reg_idx_t         exp_rd [$];
    rv_pipe_pkg::data_t            exp_data [$];
    logic                          exp_taken [$];       // two bubbles follow

    logic [31:0]                   lcg_state;
    int                            mismatches;
    int                            failures;

    rv_pipe_top dut0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .imem_rdata_i   (imem_rdata_i),
        .imem_addr_o    (imem_addr_o),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_we_o    (retire_we_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    assign imem_rdata_i = imem[imem_addr_o[9:2]];     // same-cycle instruction answer

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;                    // 40 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:8]) % n;                      // low bits of an lcg cycle fast
    endfunction

    // rv32i alu semantics for op and op-imm
    function automatic rv_pipe_pkg::data_t alu_result(logic [2:0] f3, logic alt,
                                                      rv_pipe_pkg::data_t a,
                                                      rv_pipe_pkg::data_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? rv_pipe_pkg::data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, rv_pipe_pkg::data_t a,
                                          rv_pipe_pkg::data_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_addr(input string name, input rv_pipe_pkg::addr_t exp,
                              input rv_pipe_pkg::addr_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input rv_pipe_pkg::reg_idx_t exp,
                             input rv_pipe_pkg::reg_idx_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input rv_pipe_pkg::data_t exp,
                              input rv_pipe_pkg::data_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s expected %b actual %b", name, exp, act);
        end
    endtask

    // random program, forward control flow only so it always reaches the end
    task automatic build_program();
        int          roll;
        int          k;
        logic [31:0] r;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        for (int i = 0; i < PROG_LEN; i++) begin
            roll = rand_below(100);
            r = lcg_next();
            rd_a[i]  = rv_pipe_pkg::reg_idx_t'(rand_below(8));   // x0..x7 keeps deps dense
            rs1_a[i] = rv_pipe_pkg::reg_idx_t'(rand_below(8));
            rs2_a[i] = rv_pipe_pkg::reg_idx_t'(rand_below(8));
            f3_a[i]  = r[2:0];
            alt_a[i] = r[3] && (r[2:0] == 3'b000 || r[2:0] == 3'b101);
            k = 1 + rand_below(8);
            if (i + k > PROG_LEN - 1)
                k = PROG_LEN - 1 - i;                            // stay inside the program
            if (i == PROG_LEN - 1) begin
                kind_a[i] = K_JAL;                               // jal x0, 0 ends the program
                rd_a[i]   = 5'd0;
                k = 0;
            end else if (roll < 20) kind_a[i] = K_R;
            else if (roll < 44) kind_a[i] = K_I;
            else if (roll < 52) kind_a[i] = K_LUI;
            else if (roll < 60) kind_a[i] = K_AUIPC;
            else if (roll < 85) kind_a[i] = K_BR;
            else kind_a[i] = K_JAL;
            case (kind_a[i])
                K_R: imem[i] = {1'b0, alt_a[i], 5'b0, rs2_a[i], rs1_a[i], f3_a[i], rd_a[i],
                                7'b0110011};
                K_I: begin
                    if (f3_a[i] == 3'b000)
                        alt_a[i] = 1'b0;                         // no subi
                    if (f3_a[i] == 3'b001 || f3_a[i] == 3'b101)
                        imm12 = {1'b0, alt_a[i], 5'b0, r[20:16]};  // shamt form
                    else
                        imm12 = r[31:20];
                    imm_a[i] = {{20{imm12[11]}}, imm12};
                    imem[i]  = {imm12, rs1_a[i], f3_a[i], rd_a[i], 7'b0010011};
                end
                K_LUI, K_AUIPC: begin
                    imm_a[i] = {r[31:12], 12'b0};
                    imem[i]  = {r[31:12], rd_a[i], (kind_a[i] == K_LUI) ? 7'b0110111 : 7'b0010111};
                end
                K_BR: begin
                    k = rand_below(6);
                    f3_a[i] = (k < 2) ? 3'(k) : 3'(k + 2);       // skip the illegal 01x
                    k = 1 + rand_below(8);
                    if (i + k > PROG_LEN - 1)
                        k = PROG_LEN - 1 - i;
                    boff = 13'(k * 4);
                    imm_a[i] = 32'(k * 4);
                    imem[i]  = {boff[12], boff[10:5], rs2_a[i], rs1_a[i], f3_a[i], boff[4:1],
                                boff[11], 7'b1100011};
                end
                default: begin
                    joff = 21'(k * 4);
                    imm_a[i] = 32'(k * 4);
                    imem[i]  = {joff[20], joff[10:1], joff[11], joff[19:12], rd_a[i], 7'b1101111};
                end
            endcase
        end
        for (int i = PROG_LEN; i < MEM_WORDS; i++)
            imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011};  // addi x0 tagged by index
    endtask

    // isa-level walk of the program, one entry per retired instruction
    task automatic run_model();
        rv_pipe_pkg::data_t x [32];
        rv_pipe_pkg::data_t res;
        rv_pipe_pkg::addr_t pc;
        logic               we;
        logic               taken;
        int                 idx;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        idx = 0;
        for (int s = 0; s < PROG_LEN; s++) begin
            pc    = `RV_RESET_PC + 32'(idx * 4);
            we    = (rd_a[idx] != 5'd0);
            taken = 1'b0;
            res   = '0;
            case (kind_a[idx])
                K_R:     res = alu_result(f3_a[idx], alt_a[idx], x[rs1_a[idx]], x[rs2_a[idx]]);
                K_I:     res = alu_result(f3_a[idx], alt_a[idx], x[rs1_a[idx]], imm_a[idx]);
                K_LUI:   res = imm_a[idx];
                K_AUIPC: res = pc + imm_a[idx];
                K_BR: begin
                    we    = 1'b0;                            // branches never write
                    taken = branch_taken(f3_a[idx], x[rs1_a[idx]], x[rs2_a[idx]]);
                end
                default: begin
                    res   = pc + 32'd4;                      // link
                    taken = 1'b1;
                end
            endcase
            exp_pc.push_back(pc);
            exp_we.push_back(we);
            exp_rd.push_back(rd_a[idx]);
            exp_data.push_back(res);
            exp_taken.push_back(taken);
            if (we)
                x[rd_a[idx]] = res;
            if (idx == PROG_LEN - 1)
                break;                                       // final self jump reached
            idx = taken ? idx + int'(imm_a[idx] >> 2) : idx + 1;
        end
    endtask

    initial begin
        int                 cyc;
        int                 bubbles;
        int                 n_ret;
        logic               exp_v;
        logic               done;
        logic               t_we;
        string              name;
        rv_pipe_pkg::reg_idx_t t_rd;
        rv_pipe_pkg::data_t t_data;
        rv_pipe_pkg::addr_t t_pc;
        rst_n_i    = 1'b0;
        mismatches = 0;
        failures   = 0;
        lcg_state  = 32'h6cf14b3e;
        build_program();
        run_model();
        for (int c = 0; c < 16; c++) begin
            @(negedge clk_i);
            check_bit("reset retire_valid", 1'b0, retire_valid_o);
            check_addr("reset imem_addr", `RV_RESET_PC, imem_addr_o);
        end
        rst_n_i = 1'b1;                                       // release on a falling edge
        check_bit("release retire_valid", 1'b0, retire_valid_o);
        check_addr("release imem_addr", `RV_RESET_PC, imem_addr_o);
        cyc     = 0;
        bubbles = 0;
        n_ret   = 0;
        done    = 1'b0;
        while (!done && cyc < RUN_LIMIT) begin
            @(negedge clk_i);
            cyc++;
            if (cyc < 3) begin
                exp_v = 1'b0;                                 // pipeline still filling
            end else if (bubbles > 0) begin
                exp_v = 1'b0;
                bubbles--;
            end else begin
                exp_v = 1'b1;
            end
            check_bit($sformatf("cycle %0d retire_valid", cyc), exp_v, retire_valid_o);
            if (retire_valid_o === 1'b1) begin
                t_pc   = exp_pc.pop_front();
                t_we   = exp_we.pop_front();
                t_rd   = exp_rd.pop_front();
                t_data = exp_data.pop_front();
                bubbles = exp_taken.pop_front() ? 2 : 0;
                name = $sformatf("retire %0d", n_ret);
                check_addr({name, " pc"}, t_pc, retire_pc_o);
                check_bit({name, " we"}, t_we, retire_we_o);
                if (t_we) begin                               // rd and data only mean something on a write
                    check_reg({name, " rd"}, t_rd, retire_rd_o);
                    check_data({name, " data"}, t_data, retire_data_o);
                end
                n_ret++;
                if (exp_pc.size() == 0)
                    done = 1'b1;
            end
        end
        if (!done) begin
            failures++;
            $display("retirement stalled: %0d of %0d instructions retired in %0d cycles",
                     n_ret, n_ret + exp_pc.size(), cyc);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hdl
hdl/rv_pipe_pkg.sv
hdl/fetch_unit.sv
hdl/decoder.sv
hdl/reg_file.sv
hdl/reg_d_to_e.sv
hdl/rv_pipe_top.sv
sim/tb_rv_pipe.sv
